// ==== verilog/decode_settings.svh ====
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

////////////////////////////////////////////////
// Datapath sizes

`define XLEN 32
`define REG_COUNT 32

////////////////////////////////////////////////
// Exception cause codes, machine mode

`define CAUSE_ILLEGAL 2
`define CAUSE_BREAKPOINT 3
`define CAUSE_ECALL_M 11

`endif

// ==== verilog/decode_pkg.sv ====
`default_nettype none

`include "decode_settings.svh"

package decode_pkg;

    ////////////////////////////////////////////////
    // Operation encodings

    typedef enum logic [3:0] {
        op_none,
        op_alu,
        op_alu_imm,
        op_lui,
        op_auipc,
        op_jal,
        op_jalr,
        op_branch,
        op_load,
        op_store,
        op_fence,
        op_system
    } op_class_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_t;

    // Values follow funct3 of the load and store encodings
    typedef enum logic [2:0] {
        mem_byte = 3'd0,
        mem_half = 3'd1,
        mem_word = 3'd2,
        mem_byte_u = 3'd4,
        mem_half_u = 3'd5
    } mem_op_t;

    ////////////////////////////////////////////////
    // Records between the blocks

    typedef struct packed {
        logic valid;
        logic [`XLEN-1:0] pc;
        logic [31:0] instr;
    } fetch_packet_t;

    typedef struct packed {
        logic [`XLEN-1:0] imm;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic wren;
        logic rden1;
        logic rden2;
        op_class_t op_class;
        alu_op_t alu_op;
        mem_op_t mem_op;
        logic legal;
        logic ecall;
        logic ebreak;
    } decode_fields_t;

    typedef struct packed {
        logic wren;
        logic [4:0] waddr;
        logic [`XLEN-1:0] wdata;
    } writeback_t;

    typedef struct packed {
        logic rden1;
        logic [4:0] raddr1;
        logic rden2;
        logic [4:0] raddr2;
    } reg_read_t;

    typedef struct packed {
        logic [`XLEN-1:0] rdata1;
        logic [`XLEN-1:0] rdata2;
    } reg_data_t;

    typedef struct packed {
        logic valid;
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] npc;
        logic [31:0] instr;
        decode_fields_t fields;
        logic [`XLEN-1:0] rdata1;
        logic [`XLEN-1:0] rdata2;
        logic exception;
        logic [3:0] ecause;
        logic [`XLEN-1:0] etval;
    } decode_result_t;

endpackage

`default_nettype wire

// ==== verilog/base_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module base_decoder (
    input  logic [31:0] instr,
    output decode_pkg::decode_fields_t fields
);
    import decode_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;

    // Shared by register and immediate forms, alt selects sub and sra
    function automatic alu_op_t alu_from_funct3(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000: return alt ? alu_sub : alu_add;
            3'b001: return alu_sll;
            3'b010: return alu_slt;
            3'b011: return alu_sltu;
            3'b100: return alu_xor;
            3'b101: return alt ? alu_sra : alu_srl;
            3'b110: return alu_or;
            default: return alu_and;
        endcase
    endfunction

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        fields = '0;
        fields.rd = instr[11:7];
        fields.rs1 = instr[19:15];
        fields.rs2 = instr[24:20];
        case (opcode)
            7'b0110111, 7'b0010111: begin
                fields.op_class = opcode[5] ? op_lui : op_auipc;
                fields.imm = imm_u;
                fields.wren = 1'b1;
                fields.legal = 1'b1;
            end
            7'b1101111: begin
                fields.op_class = op_jal;
                fields.imm = imm_j;
                fields.wren = 1'b1;
                fields.legal = 1'b1;
            end
            7'b1100111: begin
                fields.op_class = op_jalr;
                fields.imm = imm_i;
                fields.wren = 1'b1;
                fields.rden1 = 1'b1;
                fields.legal = funct3 == 3'b000;
            end
            7'b1100011: begin
                fields.op_class = op_branch;
                fields.imm = imm_b;
                fields.rden1 = 1'b1;
                fields.rden2 = 1'b1;
                fields.alu_op = funct3[2] ? (funct3[1] ? alu_sltu : alu_slt) : alu_sub;
                fields.legal = funct3[2:1] != 2'b01;
            end
            7'b0000011: begin
                fields.op_class = op_load;
                fields.imm = imm_i;
                fields.wren = 1'b1;
                fields.rden1 = 1'b1;
                fields.mem_op = mem_op_t'(funct3);
                fields.legal = funct3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
            end
            7'b0100011: begin
                fields.op_class = op_store;
                fields.imm = imm_s;
                fields.rden1 = 1'b1;
                fields.rden2 = 1'b1;
                fields.mem_op = mem_op_t'(funct3);
                fields.legal = funct3 inside {3'd0, 3'd1, 3'd2};
            end
            7'b0010011: begin
                fields.op_class = op_alu_imm;
                fields.imm = imm_i;
                fields.wren = 1'b1;
                fields.rden1 = 1'b1;
                fields.alu_op = alu_from_funct3(funct3, funct3 == 3'b101 && instr[30]);
                fields.legal = funct3[1:0] != 2'b01 || funct7 == 7'b0
                               || (funct3 == 3'b101 && funct7 == 7'b0100000);
            end
            7'b0110011: begin
                fields.op_class = op_alu;
                fields.wren = 1'b1;
                fields.rden1 = 1'b1;
                fields.rden2 = 1'b1;
                fields.alu_op = alu_from_funct3(funct3, instr[30]);
                fields.legal = funct7 == 7'b0 || (funct7 == 7'b0100000
                               && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            7'b0001111: begin
                fields.op_class = op_fence; // Executes as a nop
                fields.legal = funct3 == 3'b000;
            end
            7'b1110011: begin
                fields.op_class = op_system;
                fields.ecall = instr[31:7] == 25'b0;
                fields.ebreak = instr[31:7] == {12'h001, 13'b0};
                fields.legal = fields.ecall || fields.ebreak;
            end
            default: fields.legal = 1'b0;
        endcase

        fields.legal = fields.legal && instr[1:0] == 2'b11;
        fields.wren = fields.wren && fields.rd != 5'd0; // x0 writes are nops

        if (!fields.wren) fields.rd = '0;
        if (!fields.rden1) fields.rs1 = '0;
        if (!fields.rden2) fields.rs2 = '0;
    end

endmodule

`default_nettype wire

// ==== verilog/compressed_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module compressed_decoder (
    input  logic [15:0] instr,
    output decode_pkg::decode_fields_t fields
);
    import decode_pkg::*;

    logic [4:0] rd_full;
    logic [4:0] rs2_full;
    logic [4:0] rd_prime;
    logic [4:0] rs1_prime;
    logic [31:0] imm_ci;
    logic [31:0] imm_lui;
    logic [31:0] imm_cj;
    logic [31:0] imm_lw;

    assign rd_full = instr[11:7];
    assign rs2_full = instr[6:2];
    assign rd_prime = {2'b01, instr[4:2]};  // x8 to x15
    assign rs1_prime = {2'b01, instr[9:7]};

    assign imm_ci = {{27{instr[12]}}, instr[6:2]};
    assign imm_lui = {{15{instr[12]}}, instr[6:2], 12'b0};
    assign imm_cj = {{21{instr[12]}}, instr[8], instr[10:9], instr[6], instr[7], instr[2],
                     instr[11], instr[5:3], 1'b0};
    assign imm_lw = {25'b0, instr[5], instr[12:10], instr[6], 2'b0};

    always_comb begin
        fields = '0;
        case ({instr[15:13], instr[1:0]})
            5'b010_00: begin // c.lw
                fields.op_class = op_load;
                fields.mem_op = mem_word;
                fields.imm = imm_lw;
                fields.rd = rd_prime;
                fields.rs1 = rs1_prime;
                fields.wren = 1'b1;
                fields.rden1 = 1'b1;
                fields.legal = 1'b1;
            end
            5'b110_00: begin // c.sw
                fields.op_class = op_store;
                fields.mem_op = mem_word;
                fields.imm = imm_lw;
                fields.rs1 = rs1_prime;
                fields.rs2 = rd_prime;
                fields.rden1 = 1'b1;
                fields.rden2 = 1'b1;
                fields.legal = 1'b1;
            end
            5'b000_01, 5'b010_01: begin // c.addi, c.nop, c.li
                fields.op_class = op_alu_imm;
                fields.imm = imm_ci;
                fields.rd = rd_full;
                fields.rs1 = instr[14] ? 5'd0 : rd_full;
                fields.wren = 1'b1;
                fields.rden1 = 1'b1;
                fields.legal = 1'b1;
            end
            5'b001_01, 5'b101_01: begin // c.jal links to x1, c.j does not
                fields.op_class = op_jal;
                fields.imm = imm_cj;
                fields.rd = instr[15] ? 5'd0 : 5'd1;
                fields.wren = 1'b1;
                fields.legal = 1'b1;
            end
            5'b011_01: begin
                // x2 selects c.addi16sp, outside the subset
                fields.op_class = op_lui;
                fields.imm = imm_lui;
                fields.rd = rd_full;
                fields.wren = 1'b1;
                fields.legal = rd_full != 5'd2 && imm_lui != '0;
            end
            5'b100_10: begin
                fields.rd = rd_full;
                fields.rs1 = rd_full;
                fields.rs2 = rs2_full;
                if (rs2_full != 5'd0) begin // c.mv, c.add
                    fields.op_class = op_alu;
                    fields.rs1 = instr[12] ? rd_full : 5'd0;
                    fields.wren = 1'b1;
                    fields.rden1 = 1'b1;
                    fields.rden2 = 1'b1;
                    fields.legal = 1'b1;
                end else if (!instr[12]) begin // c.jr
                    fields.op_class = op_jalr;
                    fields.rd = 5'd0;
                    fields.rden1 = 1'b1;
                    fields.legal = rd_full != 5'd0;
                end else if (rd_full == 5'd0) begin // c.ebreak
                    fields.op_class = op_system;
                    fields.ebreak = 1'b1;
                    fields.legal = 1'b1;
                end
            end
            default: fields.legal = 1'b0;
        endcase

        fields.wren = fields.wren && fields.rd != 5'd0;

        if (!fields.wren) fields.rd = '0;
        if (!fields.rden1) fields.rs1 = '0;
        if (!fields.rden2) fields.rs2 = '0;
    end

endmodule

`default_nettype wire

// ==== verilog/register_file.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "decode_settings.svh"

module register_file (
    input  logic clock,
    input  logic reset,
    input  decode_pkg::reg_read_t read_req,
    output decode_pkg::reg_data_t read_data,
    input  decode_pkg::writeback_t writeback
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    // Same-cycle write shows through to the reader
    function automatic logic [`XLEN-1:0] read_word(input logic rden, input logic [4:0] raddr);
        if (!rden || raddr == 5'd0) begin
            return '0;
        end
        if (writeback.wren && writeback.waddr == raddr) begin
            return writeback.wdata;
        end
        return regs[raddr];
    endfunction

    always_ff @(posedge clock) begin
        if (reset == 0) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeback.wren && writeback.waddr != 5'd0) begin
            regs[writeback.waddr] <= writeback.wdata;
        end
    end

    always_comb begin
        read_data.rdata1 = read_word(read_req.rden1, read_req.raddr1);
        read_data.rdata2 = read_word(read_req.rden2, read_req.raddr2);
    end

    zero_reg_kept: assert property (@(posedge clock) disable iff (reset == 0)
        regs[0] == '0)
        else $error("register x0 was written");

endmodule

`default_nettype wire

// ==== verilog/decode_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "decode_settings.svh"

module decode_stage (
    input  logic clock,
    input  logic reset,
    input  decode_pkg::fetch_packet_t fetch,
    input  logic hold,
    input  logic flush,
    output logic [31:0] instr_word,
    input  decode_pkg::decode_fields_t base_fields,
    input  decode_pkg::decode_fields_t compressed_fields,
    output decode_pkg::reg_read_t read_req,
    input  decode_pkg::reg_data_t read_data,
    output decode_pkg::decode_result_t decoded
);
    import decode_pkg::*;

    logic compressed;
    decode_fields_t fields;
    decode_result_t rec;

    assign instr_word = fetch.instr;
    assign compressed = fetch.instr[1:0] != 2'b11;
    assign fields = compressed ? compressed_fields : base_fields;

    always_comb begin
        read_req.rden1 = fields.rden1;
        read_req.raddr1 = fields.rs1;
        read_req.rden2 = fields.rden2;
        read_req.raddr2 = fields.rs2;
    end

    ////////////////////////////////////////////////
    // Record for execute

    always_comb begin
        rec = '0;
        rec.valid = fetch.valid;
        rec.pc = fetch.pc;
        rec.npc = fetch.pc + (compressed ? `XLEN'(2) : `XLEN'(4));
        rec.instr = fetch.instr;
        rec.fields = fields;
        rec.rdata1 = read_data.rdata1;
        rec.rdata2 = read_data.rdata2;

        if (!fields.legal) begin // Highest priority
            rec.exception = 1'b1;
            rec.ecause = 4'(`CAUSE_ILLEGAL);
        end else if (fields.ebreak) begin
            rec.exception = 1'b1;
            rec.ecause = 4'(`CAUSE_BREAKPOINT);
        end else if (fields.ecall) begin
            rec.exception = 1'b1;
            rec.ecause = 4'(`CAUSE_ECALL_M);
        end

        if (rec.exception) begin
            rec.etval = fetch.instr;
            rec.fields.wren = 1'b0;  // Trapping instruction retires nothing
        end

        if (!fetch.valid) begin
            rec = '0;
        end
    end

    // Flush beats hold
    always_ff @(posedge clock) begin
        if (reset == 0 || flush) begin
            decoded <= '0;
        end else if (!hold) begin
            decoded <= rec;
        end
    end

    ////////////////////////////////////////////////
    // Checks

    exception_valid: assert property (@(posedge clock) disable iff (reset == 0)
        decoded.exception |-> decoded.valid)
        else $error("exception raised on an invalid record");

    wren_target: assert property (@(posedge clock) disable iff (reset == 0)
        decoded.fields.wren |-> decoded.fields.rd != 5'd0
                                || decoded.fields.op_class == op_none)
        else $error("write enabled towards x0");

endmodule

`default_nettype wire

// ==== verilog/decode_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module decode_top (
    input  logic clock,
    input  logic reset,
    input  decode_pkg::fetch_packet_t fetch,
    input  logic hold,
    input  logic flush,
    input  decode_pkg::writeback_t writeback,
    output decode_pkg::decode_result_t decoded
);
    import decode_pkg::*;

    logic [31:0] instr_word;
    decode_fields_t base_fields;
    decode_fields_t compressed_fields;
    reg_read_t read_req;
    reg_data_t read_data;

    base_decoder i_base_decoder (
        .instr(instr_word),
        .fields(base_fields)
    );

    compressed_decoder i_compressed_decoder (
        .instr(instr_word[15:0]),   // Upper half ignored
        .fields(compressed_fields)
    );

    register_file i_register_file (
        .clock(clock),
        .reset(reset),
        .read_req(read_req),
        .read_data(read_data),
        .writeback(writeback)
    );

    decode_stage i_decode_stage (
        .clock(clock),
        .reset(reset),
        .fetch(fetch),
        .hold(hold),
        .flush(flush),
        .instr_word(instr_word),
        .base_fields(base_fields),
        .compressed_fields(compressed_fields),
        .read_req(read_req),
        .read_data(read_data),
        .decoded(decoded)
    );

endmodule

`default_nettype wire

// ==== test/decode_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "decode_settings.svh"

module decode_tb;
    import decode_pkg::*;

    localparam int CYCLES = 800;

    logic clock;
    logic reset;
    fetch_packet_t fetch;
    logic hold;
    logic flush;
    writeback_t writeback;
    decode_result_t decoded;

    logic [31:0] lfsr_state = 32'hccca;
    logic [`XLEN-1:0] reg_model [`REG_COUNT];
    decode_result_t expected_q [$];

    decode_top i_decode_top (
        .clock(clock),
        .reset(reset),
        .fetch(fetch),
        .hold(hold),
        .flush(flush),
        .writeback(writeback),
        .decoded(decoded)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    //////////////////////////////////////////////////
    // Random source

    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < count; i++) begin
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 32'h80200003;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic logic [15:0] build_compressed();
        logic [3:0] pick;
        logic [15:0] r;
        logic [4:0] rd;
        logic [5:0] imm6;
        pick = 4'(random_bits(4));
        r = 16'(random_bits(16));
        rd = r[11:7];
        imm6 = {r[12], r[6:2]};
        case (pick)
            0: return {3'b010, r[12:2], 2'b00};            // c.lw
            1: return {3'b110, r[12:2], 2'b00};            // c.sw
            3: return {3'b010, r[12:2], 2'b01};            // c.li
            4: return 16'h0001;                            // c.nop
            5: return {3'b001, r[12:2], 2'b01};            // c.jal
            6: return {3'b101, r[12:2], 2'b01};            // c.j
            7: begin                                       // c.lui
                if (rd == 5'd0 || rd == 5'd2) rd = 5'd3;
                if (imm6 == 6'd0) imm6 = 6'd1;
                return {3'b011, imm6[5], rd, imm6[4:0], 2'b01};
            end
            8, 9: begin                                    // c.mv, c.add
                return {3'b100, pick[0], rd, (r[6:2] == 5'd0 ? 5'd1 : r[6:2]), 2'b10};
            end
            10: return {4'b1000, (rd == 5'd0 ? 5'd5 : rd), 5'd0, 2'b10}; // c.jr
            11: return 16'h9002;                           // c.ebreak
            12: return 16'h0000;                           // Reserved
            default: return {3'b000, r[12:2], 2'b01};      // c.addi
        endcase
    endfunction

    function automatic logic [31:0] build_instruction();
        logic [3:0] kind;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [2:0] f3;
        logic [6:0] f7;
        logic [31:0] r;
        kind = 4'(random_bits(4));
        rd = 5'(random_bits(5));
        rs1 = 5'(random_bits(5));
        rs2 = 5'(random_bits(5));
        f3 = 3'(random_bits(3));
        r = random_bits(32);
        case (kind)
            0: return {r[31:12], rd, 7'b0110111};
            1: return {r[31:12], rd, 7'b0010111};
            2: return {r[31:12], rd, 7'b1101111};
            3: return {r[31:20], rs1, 3'b000, rd, 7'b1100111};
            4: begin
                if (f3[2:1] == 2'b01) f3[2] = 1'b1;
                return {r[31:25], rs2, rs1, f3, r[11:7], 7'b1100011};
            end
            5: begin
                if (f3 == 3'd3 || f3[2:1] == 2'b11) f3 = f3 & 3'b101;
                return {r[31:20], rs1, f3, rd, 7'b0000011};
            end
            6: begin
                f3 = {1'b0, (f3[1:0] == 2'b11 ? 2'b10 : f3[1:0])};
                return {r[31:25], rs2, rs1, f3, r[11:7], 7'b0100011};
            end
            7: begin
                f7 = f3[1:0] == 2'b01 ? {1'b0, f3[2] & r[30], 5'b0} : r[31:25];
                return {f7, r[24:20], rs1, f3, rd, 7'b0010011};
            end
            8: begin
                f7 = ((f3 == 3'd0 || f3 == 3'd5) && r[30]) ? 7'b0100000 : 7'b0;
                return {f7, rs2, rs1, f3, rd, 7'b0110011};
            end
            9: return {r[31:15], 3'b000, r[11:7], 7'b0001111};
            10: return r[0] ? 32'h00100073 : 32'h00000073; // ebreak or ecall
            11: return {r[31:7], 7'b1111111};               // No such opcode
            default: return {r[31:16], build_compressed()};
        endcase
    endfunction

    //////////////////////////////////////////////////
    // Reference model

    function automatic alu_op_t expected_alu(input logic [2:0] f3, input logic alt);
        case (f3)
            3'd0: return alt ? alu_sub : alu_add;
            3'd1: return alu_sll;
            3'd2: return alu_slt;
            3'd3: return alu_sltu;
            3'd4: return alu_xor;
            3'd5: return alt ? alu_sra : alu_srl;
            3'd6: return alu_or;
            default: return alu_and;
        endcase
    endfunction

    // Unused register fields read as zero, x0 targets never write
    function automatic decode_fields_t tidy_fields(input decode_fields_t f);
        f.wren = f.wren && f.rd != 5'd0;
        if (!f.wren) f.rd = '0;
        if (!f.rden1) f.rs1 = '0;
        if (!f.rden2) f.rs2 = '0;
        return f;
    endfunction

    function automatic decode_fields_t expect_base(input logic [31:0] w);
        decode_fields_t f;
        logic [2:0] f3;
        f = '0;
        f3 = w[14:12];
        f.rd = w[11:7];
        f.rs1 = w[19:15];
        f.rs2 = w[24:20];
        f.legal = 1'b1;
        case (w[6:0])
            7'b0110111: {f.op_class, f.imm, f.wren} = {op_lui, w[31:12], 12'b0, 1'b1};
            7'b0010111: {f.op_class, f.imm, f.wren} = {op_auipc, w[31:12], 12'b0, 1'b1};
            7'b1101111: begin
                f.op_class = op_jal;
                f.imm = 32'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
                f.wren = 1'b1;
            end
            7'b1100111: begin
                f.op_class = op_jalr;
                f.imm = 32'($signed(w[31:20]));
                {f.wren, f.rden1} = 2'b11;
            end
            7'b1100011: begin
                f.op_class = op_branch;
                f.imm = 32'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
                {f.rden1, f.rden2} = 2'b11;
                f.alu_op = !f3[2] ? alu_sub : (f3[1] ? alu_sltu : alu_slt);
            end
            7'b0000011: begin
                f.op_class = op_load;
                f.imm = 32'($signed(w[31:20]));
                {f.wren, f.rden1} = 2'b11;
                f.mem_op = mem_op_t'(f3);
            end
            7'b0100011: begin
                f.op_class = op_store;
                f.imm = 32'($signed({w[31:25], w[11:7]}));
                {f.rden1, f.rden2} = 2'b11;
                f.mem_op = mem_op_t'(f3);
            end
            7'b0010011: begin
                f.op_class = op_alu_imm;
                f.imm = 32'($signed(w[31:20]));
                {f.wren, f.rden1} = 2'b11;
                f.alu_op = expected_alu(f3, f3 == 3'd5 && w[30]);
            end
            7'b0110011: begin
                f.op_class = op_alu;
                {f.wren, f.rden1, f.rden2} = 3'b111;
                f.alu_op = expected_alu(f3, w[30]);
            end
            7'b0001111: f.op_class = op_fence;
            7'b1110011: begin
                f.op_class = op_system;
                f.ecall = w[31:7] == 25'h0;
                f.ebreak = w[31:7] == 25'h2000;
            end
            default: f = '0;  // Illegal opcode keeps nothing
        endcase
        return tidy_fields(f);
    endfunction

    function automatic decode_fields_t expect_compressed(input logic [15:0] c);
        decode_fields_t f;
        logic [4:0] rd_full;
        logic [4:0] rs2_full;
        f = '0;
        rd_full = c[11:7];
        rs2_full = c[6:2];
        if (c[1:0] == 2'b00 && (c[15:13] == 3'b010 || c[15:13] == 3'b110)) begin
            f.op_class = c[15] ? op_store : op_load;
            f.mem_op = mem_word;
            f.imm = {25'b0, c[5], c[12:10], c[6], 2'b0};
            f.rs1 = {2'b01, c[9:7]};
            f.rden1 = 1'b1;
            if (c[15]) {f.rs2, f.rden2} = {2'b01, c[4:2], 1'b1};
            else {f.rd, f.wren} = {2'b01, c[4:2], 1'b1};
            f.legal = 1'b1;
        end else if (c[1:0] == 2'b01 && (c[15:13] == 3'b000 || c[15:13] == 3'b010)) begin
            f.op_class = op_alu_imm;
            f.imm = 32'($signed({c[12], c[6:2]}));
            f.rd = rd_full;
            f.rs1 = c[14] ? 5'd0 : rd_full;  // c.li adds to x0
            {f.wren, f.rden1, f.legal} = 3'b111;
        end else if (c[1:0] == 2'b01 && c[14:13] == 2'b01) begin
            f.op_class = op_jal;
            f.imm = 32'($signed({c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0}));
            f.rd = c[15] ? 5'd0 : 5'd1;
            {f.wren, f.legal} = 2'b11;
        end else if (c[1:0] == 2'b01 && c[15:13] == 3'b011) begin
            f.op_class = op_lui;
            f.imm = 32'($signed({c[12], c[6:2]})) << 12;
            f.rd = rd_full;
            f.wren = 1'b1;
            f.legal = rd_full != 5'd2 && {c[12], c[6:2]} != 6'd0;
        end else if (c[1:0] == 2'b10 && c[15:13] == 3'b100) begin
            if (rs2_full != 5'd0) begin
                f.op_class = op_alu;
                f.rd = rd_full;
                f.rs1 = c[12] ? rd_full : 5'd0;
                f.rs2 = rs2_full;
                {f.wren, f.rden1, f.rden2, f.legal} = 4'b1111;
            end else if (!c[12]) begin
                f.op_class = op_jalr;
                f.rs1 = rd_full;
                f.rden1 = 1'b1;
                f.legal = rd_full != 5'd0;
            end else if (rd_full == 5'd0) begin
                {f.op_class, f.ebreak, f.legal} = {op_system, 2'b11};
            end
        end
        return tidy_fields(f);
    endfunction

    function automatic logic [`XLEN-1:0] model_read(input logic en, input logic [4:0] addr);
        return (en && addr != 5'd0) ? reg_model[addr] : '0;
    endfunction

    function automatic decode_result_t ref_decode(input fetch_packet_t p);
        decode_result_t e;
        logic comp;
        e = '0;
        if (!p.valid) return e;
        comp = p.instr[1:0] != 2'b11;
        e.fields = comp ? expect_compressed(p.instr[15:0]) : expect_base(p.instr);
        e.valid = 1'b1;
        e.pc = p.pc;
        e.npc = p.pc + (comp ? 32'd2 : 32'd4);
        e.instr = p.instr;
        e.rdata1 = model_read(e.fields.rden1, e.fields.rs1);
        e.rdata2 = model_read(e.fields.rden2, e.fields.rs2);
        if (!e.fields.legal) e.ecause = 4'(`CAUSE_ILLEGAL);
        else if (e.fields.ebreak) e.ecause = 4'(`CAUSE_BREAKPOINT);
        else if (e.fields.ecall) e.ecause = 4'(`CAUSE_ECALL_M);
        if (e.ecause != 4'd0) begin
            e.exception = 1'b1;
            e.etval = p.instr;
            e.fields.wren = 1'b0;
        end
        return e;
    endfunction

    //////////////////////////////////////////////////
    // Checks

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("Test FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic compare_result(input string name, input decode_result_t got,
                                  input decode_result_t exp);
        if (got !== exp) begin
            stop_run($sformatf("Fail time=%0t signal=%s got=%h expected=%h",
                               $time, name, got, exp));
        end
    endtask

    task automatic compare_operands(input string name, input reg_data_t got,
                                    input reg_data_t exp);
        if (got !== exp) begin
            stop_run($sformatf("Fail time=%0t signal=%s got=%h expected=%h",
                               $time, name, got, exp));
        end
    endtask

    task automatic compare_exception(input logic got_exc, input logic [3:0] got_cause,
                                     input logic [31:0] got_tval, input logic exp_exc,
                                     input logic [3:0] exp_cause, input logic [31:0] exp_tval);
        if ({got_exc, got_cause, got_tval} !== {exp_exc, exp_cause, exp_tval}) begin
            stop_run($sformatf(
                "Fail time=%0t signal=decoded.exception got=%b/%0d/%h expected=%b/%0d/%h",
                $time, got_exc, got_cause, got_tval, exp_exc, exp_cause, exp_tval));
        end
    endtask

    initial begin : compare_process
        decode_result_t exp;
        int waited;
        waited = 0;
        while (reset !== 1'b1) begin
            @(posedge clock);
            waited++;
            if (waited > 100) stop_run("reset was never released");
        end
        forever begin
            @(posedge clock);
            #1;
            if (expected_q.size() > 0) begin
                exp = expected_q.pop_front();
                compare_exception(decoded.exception, decoded.ecause, decoded.etval,
                                  exp.exception, exp.ecause, exp.etval);
                compare_operands("decoded.rdata", {decoded.rdata1, decoded.rdata2},
                                 {exp.rdata1, exp.rdata2});
                compare_result("decoded", decoded, exp);
            end
        end
    end

    //////////////////////////////////////////////////
    // Stimulus

    initial begin : drive_process
        fetch_packet_t packet;
        writeback_t wb;
        decode_result_t last_expected;
        logic keep;
        logic hold_level;
        logic flush_level;
        int waited;
        reset = 1'b0;
        fetch = '0;
        hold = 1'b0;
        flush = 1'b0;
        writeback = '0;
        packet = '0;
        last_expected = '0;
        keep = 1'b0;
        for (int i = 0; i < `REG_COUNT; i++) reg_model[i] = '0;

        repeat (10) @(negedge clock);
        reset = 1'b1;
        compare_result("decoded", decoded, '0);  // Clean record before any packet

        for (int n = 0; n < CYCLES; n++) begin
            @(negedge clock);
            if (!keep) begin // A held packet stays on the bus
                packet.valid = random_bits(3) != 0;
                packet.pc = {31'(random_bits(31)), 1'b0};
                packet.instr = build_instruction();
            end
            hold_level = random_bits(3) == 0;
            flush_level = random_bits(4) == 0;
            wb.wren = random_bits(1) != 0;
            wb.waddr = random_bits(2) == 0 ? packet.instr[19:15] : 5'(random_bits(5));
            wb.wdata = random_bits(32);
            fetch = packet;
            hold = hold_level;
            flush = flush_level;
            writeback = wb;

            // Model written first, reads then see the same-cycle write
            if (wb.wren && wb.waddr != 5'd0) reg_model[wb.waddr] = wb.wdata;
            if (flush_level) begin
                last_expected = '0;
            end else if (!hold_level) begin
                last_expected = ref_decode(packet);
            end
            expected_q.push_back(last_expected);
            keep = hold_level && !flush_level;
        end

        @(negedge clock);
        fetch = '0;
        hold = 1'b0;
        flush = 1'b0;
        writeback = '0;
        waited = 0;
        while (expected_q.size() != 0) begin
            @(posedge clock);
            #2;
            waited++;
            if (waited > 20) stop_run("expected records were never checked");
        end
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== decode_subsystem.f ====
+incdir+verilog
verilog/decode_pkg.sv
verilog/base_decoder.sv
verilog/compressed_decoder.sv
verilog/register_file.sv
verilog/decode_stage.sv
verilog/decode_top.sv
test/decode_tb.sv

// ==== build.sh ====
#!/usr/bin/env bash
# Builds the decode subsystem testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --Wno-fatal -f decode_subsystem.f \
    --top-module decode_tb -o decode_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/decode_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Test FAILED" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

exit 0
